// File: hdl/arc_game_pkg.sv
// Arcade game glue definitions
package arc_game_pkg;

    // Video geometry, pixels per line and lines per frame
    localparam int H_TOTAL  = 32;
    localparam int H_ACTIVE = 24;
    localparam int V_TOTAL  = 16;
    localparam int V_ACTIVE = 12;

    // Sync placement inside the blanking intervals
    localparam int HS_START = 26;
    localparam int HS_END   = 27;
    localparam int VS_LINE  = 13;

    // Main CPU register map
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_BANK   = 2'd1,
        REG_LATCH  = 2'd2,
        REG_STATUS = 2'd3
    } reg_sel_e;

    // Main CPU bus as seen by the register block
    typedef struct packed {
        logic        cs;
        logic        rnw;
        logic [1:0]  dsn;       // Active low, bit 0 is the low byte lane
        reg_sel_e    addr;
        logic [15:0] dout;
    } cpu_bus_t;

    // Board configuration latches
    typedef struct packed {
        logic       flip;
        logic       video_en;
        logic [5:0] tile_bank;
    } sys_cfg_t;

    // Video timing bundle
    typedef struct packed {
        logic       hblank;
        logic       vblank;
        logic       hs;
        logic       vs;
        logic       vint;
        logic [7:0] hdump;
        logic [7:0] vrender;
    } vid_timing_t;

    // Tile engine requests before gating and banking
    typedef struct packed {
        logic [11:0] char_addr;
        logic [15:0] scr1_addr;
        logic [15:0] scr2_addr;
        logic [19:0] obj_addr;
    } gfx_addr_t;

    // Graphics ROM addresses after the mapper
    typedef struct packed {
        logic [11:0] char_addr;
        logic [18:0] scr1_addr;
        logic [18:0] scr2_addr;
        logic [19:0] obj_addr;
    } gfx_adj_t;

endpackage

// File: hdl/arc_cen.sv
// Clock-enable generator
`timescale 1ns/1ps

module arc_cen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen,
    output logic snd_cen
);

    // Free-running divider, every enable is decoded from it
    logic [2:0] div_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= 3'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
            snd_cen  <= 1'b0;
        end else begin
            div_cnt  <= div_cnt + 3'd1;
            // Divide by 2
            pxl2_cen <= div_cnt[0];
            // Divide by 4
            pxl_cen  <= &div_cnt[1:0];
            // Divide by 8
            snd_cen  <= &div_cnt;
        end
    end

endmodule

// File: hdl/arc_vtimer.sv
// Video timing generator
`timescale 1ns/1ps

module arc_vtimer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    output arc_game_pkg::vid_timing_t timing,
    output logic [7:0]                frame_cnt
);

    import arc_game_pkg::*;

    logic [7:0] hdump;
    logic [7:0] vrender;
    logic       vint;
    logic       line_end;
    logic       frame_end;
    logic       vint_hit;

    // Last pixel of a line and last line of a frame
    assign line_end  = hdump == 8'(H_TOTAL - 1);
    assign frame_end = vrender == 8'(V_TOTAL - 1);

    // Next enable moves to the first blank line with hdump 0
    assign vint_hit = pxl_cen && line_end && (vrender == 8'(V_ACTIVE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump   <= 8'd0;
            vrender <= 8'd0;
        end else if (pxl_cen) begin
            if (line_end) begin
                hdump <= 8'd0;
                if (frame_end) begin
                    vrender <= 8'd0;
                end else begin
                    vrender <= vrender + 8'd1;
                end
            end else begin
                hdump <= hdump + 8'd1;
            end
        end
    end

    // Interrupt pulse and frame count move on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vint      <= 1'b0;
            frame_cnt <= 8'd0;
        end else begin
            vint <= vint_hit;
            if (vint_hit) begin
                frame_cnt <= frame_cnt + 8'd1;
            end
        end
    end

    // Blanking and syncs decode straight from the counters
    assign timing.hblank  = hdump >= 8'(H_ACTIVE);
    assign timing.vblank  = vrender >= 8'(V_ACTIVE);
    assign timing.hs      = (hdump >= 8'(HS_START)) && (hdump <= 8'(HS_END));
    assign timing.vs      = vrender == 8'(VS_LINE);
    assign timing.vint    = vint;
    assign timing.hdump   = hdump;
    assign timing.vrender = vrender;

endmodule

// File: hdl/arc_mem_map.sv
// Graphics ROM address mapper
`timescale 1ns/1ps

module arc_mem_map (
    input  logic                    clk,
    input  logic                    rst_n,
    input  arc_game_pkg::sys_cfg_t  cfg,
    input  logic                    obj_cs,
    input  arc_game_pkg::gfx_addr_t pre_addr,
    output arc_game_pkg::gfx_adj_t  adj_addr,
    output logic                    gfx_cs
);

    import arc_game_pkg::*;

    gfx_adj_t adj_next;
    logic     cs_next;

    // Upper half of a scroll layer's tile space goes through its bank
    function automatic logic [18:0] bank_scroll(
        input logic [15:0] addr,
        input logic [2:0]  bank
    );
        if (addr[15]) begin
            bank_scroll = {1'b1, bank, addr[14:0]};
        end else begin
            bank_scroll = {4'd0, addr[14:0]};
        end
    endfunction

    always_comb begin
        adj_next = '0;
        // Characters only fetch with the display on
        if (cfg.video_en) begin
            adj_next.char_addr = pre_addr.char_addr;
        end
        adj_next.scr1_addr = bank_scroll(pre_addr.scr1_addr, cfg.tile_bank[2:0]);
        adj_next.scr2_addr = bank_scroll(pre_addr.scr2_addr, cfg.tile_bank[5:3]);
        if (obj_cs) begin
            adj_next.obj_addr = pre_addr.obj_addr;
        end
    end

    assign cs_next = cfg.video_en | obj_cs;

    // Single stage, a new request may enter every clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj_addr <= '0;
            gfx_cs   <= 1'b0;
        end else begin
            adj_addr <= adj_next;
            gfx_cs   <= cs_next;
        end
    end

endmodule

// File: hdl/arc_sys_regs.sv
// System control registers
`timescale 1ns/1ps

module arc_sys_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  arc_game_pkg::cpu_bus_t bus,
    output logic [15:0]            cpu_din,
    output arc_game_pkg::sys_cfg_t cfg,
    output logic [7:0]             snd_latch,
    output logic                   snd_irqn,
    input  logic                   snd_ack,
    input  logic                   vblank,
    input  logic [7:0]             frame_cnt,
    input  logic [7:0]             game_id,
    input  logic [7:0]             st_addr,
    output logic [7:0]             st_dout
);

    import arc_game_pkg::*;

    logic       wr_en;
    logic       rd_en;
    logic       latch_wr;
    logic [7:0] ctrl_byte;
    logic [7:0] rd_data;

    // Registers sit on the low byte lane only
    assign wr_en    = bus.cs && !bus.rnw && !bus.dsn[0];
    assign rd_en    = bus.cs && bus.rnw;
    assign latch_wr = wr_en && (bus.addr == REG_LATCH);

    assign ctrl_byte = {6'd0, cfg.video_en, cfg.flip};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg       <= '0;
            snd_latch <= 8'd0;
        end else if (wr_en) begin
            case (bus.addr)
                REG_CTRL: begin
                    cfg.flip     <= bus.dout[0];
                    cfg.video_en <= bus.dout[1];
                end
                REG_BANK:  cfg.tile_bank <= bus.dout[5:0];
                REG_LATCH: snd_latch     <= bus.dout[7:0];
                // Status is read-only
                default: ;
            endcase
        end
    end

    // Latch interrupt, a new write beats the acknowledge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_irqn <= 1'b1;
        end else if (latch_wr) begin
            snd_irqn <= 1'b0;
        end else if (snd_ack) begin
            snd_irqn <= 1'b1;
        end
    end

    always_comb begin
        case (bus.addr)
            REG_CTRL:  rd_data = ctrl_byte;
            REG_BANK:  rd_data = {2'd0, cfg.tile_bank};
            REG_LATCH: rd_data = snd_latch;
            default:   rd_data = {snd_irqn, vblank, frame_cnt[5:0]};
        endcase
    end

    // CPU read data, valid the clk after the access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_din <= 16'd0;
        end else if (rd_en) begin
            cpu_din <= {8'd0, rd_data};
        end
    end

    // Debug status port, unmapped addresses keep the last value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_dout <= 8'd0;
        end else begin
            case (st_addr[7:4])
                4'd0: st_dout <= frame_cnt;
                4'd1: begin
                    case (st_addr[3:0])
                        4'd0: st_dout <= snd_latch;
                        4'd1: st_dout <= {2'd0, cfg.tile_bank};
                        4'd2: st_dout <= game_id;
                        default: ;
                    endcase
                end
                4'd2, 4'd3: st_dout <= ctrl_byte;
                default: ;
            endcase
        end
    end

endmodule

// File: hdl/arc_game.sv
// Arcade game glue top level
`timescale 1ns/1ps

module arc_game (
    input  logic                      clk,
    input  logic                      rst_n,
    // Main CPU
    input  arc_game_pkg::cpu_bus_t    bus,
    output logic [15:0]               cpu_din,
    // Debug status
    input  logic [7:0]                game_id,
    input  logic [7:0]                st_addr,
    output logic [7:0]                st_dout,
    // Sound CPU side
    output logic [7:0]                snd_latch,
    output logic                      snd_irqn,
    input  logic                      snd_ack,
    // Tile engine requests
    input  logic                      obj_cs,
    input  arc_game_pkg::gfx_addr_t   pre_addr,
    output arc_game_pkg::gfx_adj_t    adj_addr,
    output logic                      gfx_cs,
    // Clock enables and video
    output logic                      pxl_cen,
    output logic                      pxl2_cen,
    output logic                      snd_cen,
    output arc_game_pkg::vid_timing_t timing,
    output logic                      flip
);

    import arc_game_pkg::*;

    sys_cfg_t   cfg;
    logic [7:0] frame_cnt;

    assign flip = cfg.flip;

    arc_cen u_cen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .snd_cen  ( snd_cen  )
    );

    arc_vtimer u_vtimer (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .timing    ( timing    ),
        .frame_cnt ( frame_cnt )
    );

    arc_mem_map u_mem_map (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cfg      ( cfg      ),
        .obj_cs   ( obj_cs   ),
        .pre_addr ( pre_addr ),
        .adj_addr ( adj_addr ),
        .gfx_cs   ( gfx_cs   )
    );

    arc_sys_regs u_sys_regs (
        .clk       ( clk           ),
        .rst_n     ( rst_n         ),
        .bus       ( bus           ),
        .cpu_din   ( cpu_din       ),
        .cfg       ( cfg           ),
        .snd_latch ( snd_latch     ),
        .snd_irqn  ( snd_irqn      ),
        .snd_ack   ( snd_ack       ),
        .vblank    ( timing.vblank ),
        .frame_cnt ( frame_cnt     ),
        .game_id   ( game_id       ),
        .st_addr   ( st_addr       ),
        .st_dout   ( st_dout       )
    );

endmodule

// File: dv/arc_game_checks.svh
// Reference model and compare tasks

// Scroll tiles in the upper half come from the layer's bank
function automatic logic [18:0] scroll_bank_addr(input logic [15:0] addr, input logic [2:0] bank);
    if (!addr[15])
        return 19'(addr[14:0]);
    return 19'h40000 | (19'(bank) << 15) | 19'(addr[14:0]);
endfunction

function automatic gfx_adj_t map_request(input sys_cfg_t cfg, input logic ocs,
                                         input gfx_addr_t req);
    gfx_adj_t adj;
    adj.char_addr = cfg.video_en ? req.char_addr : 12'd0;
    adj.scr1_addr = scroll_bank_addr(req.scr1_addr, cfg.tile_bank[2:0]);
    adj.scr2_addr = scroll_bank_addr(req.scr2_addr, cfg.tile_bank[5:3]);
    adj.obj_addr  = ocs ? req.obj_addr : 20'd0;
    return adj;
endfunction

function automatic vid_timing_t raster_timing(input int h, input int v, input logic vint);
    return {h >= H_ACTIVE, v >= V_ACTIVE, (h >= HS_START) && (h <= HS_END), v == VS_LINE,
            vint, 8'(h), 8'(v)};
endfunction

function automatic logic [7:0] reg_value(input reg_sel_e sel);
    case (sel)
        REG_CTRL:  return {6'd0, m_cfg.video_en, m_cfg.flip};
        REG_BANK:  return {2'd0, m_cfg.tile_bank};
        REG_LATCH: return m_latch;
        default:   return {m_irqn, m_v >= V_ACTIVE, m_frame[5:0]};
    endcase
endfunction

// Unmapped status addresses keep the previous byte
function automatic logic [7:0] status_value(input logic [7:0] addr, input logic [7:0] prev);
    if (addr[7:4] == 4'd0)
        return m_frame;
    if (addr[7:5] == 3'b001)
        return reg_value(REG_CTRL);
    if (addr[7:4] != 4'd1)
        return prev;
    case (addr[3:0])
        4'd0:    return m_latch;
        4'd1:    return reg_value(REG_BANK);
        4'd2:    return game_id;
        default: return prev;
    endcase
endfunction

task automatic report_mismatch(input string what, input string detail);
    $display("mismatch at %0t ns: %s, %s", $time, what, detail);
    abort_run("a DUT output differs from the expected value");
endtask

task automatic check_cfg(input string what, input sys_cfg_t got, input sys_cfg_t exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("got %h expected %h", got, exp));
endtask

task automatic check_adj(input string what, input gfx_adj_t got, input gfx_adj_t exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("got %h expected %h", got, exp));
endtask

task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("got %h expected %h", got, exp));
endtask

task automatic check_timing(input string what, input vid_timing_t got, input vid_timing_t exp);
    if (got !== exp)
        report_mismatch(what, $sformatf("got h %0d v %0d flags %b expected h %0d v %0d flags %b",
                        got.hdump, got.vrender, got[20:16], exp.hdump, exp.vrender, exp[20:16]));
endtask

task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
        report_mismatch(what, $sformatf("got %0d expected %0d", got, exp));
endtask

// File: dv/arc_game_tb.sv
// Arcade game glue testbench
`timescale 1ns/1ps

module arc_game_tb;

    import arc_game_pkg::*;

    logic        clk;
    logic        rst_n;
    cpu_bus_t    bus;
    logic [15:0] cpu_din;
    logic [7:0]  game_id;
    logic [7:0]  st_addr;
    logic [7:0]  st_dout;
    logic [7:0]  snd_latch;
    logic        snd_irqn;
    logic        snd_ack;
    logic        obj_cs;
    logic        gfx_cs;
    logic        flip;
    logic        pxl_cen;
    logic        pxl2_cen;
    logic        snd_cen;
    gfx_addr_t   pre_addr;
    gfx_adj_t    adj_addr;
    vid_timing_t timing;
    logic [3:0]  pulses;

    // Mirror of the register block and the raster counters
    sys_cfg_t    m_cfg;
    logic [7:0]  m_latch;
    logic [7:0]  m_frame;
    logic        m_irqn;
    logic        m_vint;
    int          m_h;
    int          m_v;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "arc_game_checks.svh"

    arc_game dut_i (.*);

    assign pulses = {timing.vint, snd_cen, pxl_cen, pxl2_cen};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Pixel enable that lands on hdump 0 of the first blank line raises vint
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_h     <= 0;
            m_v     <= 0;
            m_vint  <= 1'b0;
            m_frame <= 8'd0;
        end else begin
            m_vint <= pxl_cen && (m_h == H_TOTAL - 1) && (m_v == V_ACTIVE - 1);
            if (pxl_cen && (m_h == H_TOTAL - 1) && (m_v == V_ACTIVE - 1))
                m_frame <= m_frame + 8'd1;
            if (pxl_cen) begin
                m_h <= (m_h + 1) % H_TOTAL;
                if (m_h == H_TOTAL - 1)
                    m_v <= (m_v + 1) % V_TOTAL;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n)
            check_timing("raster timing", timing, raster_timing(m_h, m_v, m_vint));
    end

    // Count clk up to the next enable or vint pulse
    task automatic wait_event(input int sel, input int limit, input string what, output int gap);
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
            if (gap > limit)
                abort_run({"timeout, no ", what, " pulse arrived"});
        end while (!pulses[sel]);
    endtask

    task automatic bus_write(input reg_sel_e sel, input logic [1:0] dsn, input logic [15:0] data);
        bus = {1'b1, 1'b0, dsn, sel, data};
        @(negedge clk);
        bus.cs = 1'b0;
        // Only the low byte lane reaches the registers
        if (!dsn[0]) begin
            case (sel)
                REG_CTRL: begin
                    m_cfg.flip     = data[0];
                    m_cfg.video_en = data[1];
                end
                REG_BANK:  m_cfg.tile_bank = data[5:0];
                REG_LATCH: begin
                    m_latch = data[7:0];
                    m_irqn  = 1'b0;
                end
                default: ;
            endcase
        end
        check_cfg("board configuration", dut_i.cfg, m_cfg);
        check_byte("flip pin", {7'd0, flip}, {7'd0, m_cfg.flip});
        check_byte("sound latch", snd_latch, m_latch);
        check_byte("sound irqn", {7'd0, snd_irqn}, {7'd0, m_irqn});
    endtask

    task automatic bus_read(input reg_sel_e sel);
        logic [7:0] exp;
        bus = {1'b1, 1'b1, 2'b00, sel, 16'd0};
        exp = reg_value(sel);
        @(negedge clk);
        bus.cs = 1'b0;
        check_byte("register read", cpu_din[7:0], exp);
        check_byte("register read upper byte", cpu_din[15:8], 8'd0);
    endtask

    task automatic send_ack();
        snd_ack = 1'b1;
        @(negedge clk);
        snd_ack = 1'b0;
        m_irqn  = 1'b1;
        check_byte("sound irqn after ack", {7'd0, snd_irqn}, 8'd1);
    endtask

    initial begin
        int         gap;
        int         hb_cnt;
        int         vb_lines;
        logic [7:0] exp_st;
        reg_sel_e   sel;
        gfx_adj_t   exp_adj;
        logic       exp_cs;

        void'($urandom(32'h9edc_ad5a));
        rst_n    = 1'b0;
        bus      = '0;
        game_id  = 8'($urandom);
        st_addr  = 8'd0;
        snd_ack  = 1'b0;
        obj_cs   = 1'b0;
        pre_addr = '0;
        m_cfg    = '0;
        m_latch  = 8'd0;
        m_irqn   = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Enable periods of 2, 4 and 8 clk
        for (int s = 0; s < 3; s++) begin
            wait_event(s, 32, "clock enable", gap);
            repeat (64) begin
                wait_event(s, 32, "clock enable", gap);
                check_count("clock enable period", gap, 2 << s);
            end
        end

        // One whole frame between two vint pulses
        wait_event(3, 4096, "vint", gap);
        gap      = 0;
        hb_cnt   = 0;
        vb_lines = 0;
        do begin
            @(negedge clk);
            gap++;
            if (gap > 4096)
                abort_run("timeout, the second vint pulse never came");
            if (pxl_cen && timing.hblank)
                hb_cnt++;
            if (pxl_cen && timing.vblank && timing.hdump == 8'd0)
                vb_lines++;
        end while (!timing.vint);
        check_count("vint spacing", gap, H_TOTAL * V_TOTAL * 4);
        check_count("hblank pixel enables per frame", hb_cnt, 8 * V_TOTAL);
        check_count("vblank lines per frame", vb_lines, 4);

        // Frame count through status address 0 and REG_STATUS
        exp_st = m_frame;
        bus_read(REG_STATUS);
        check_byte("status frame count", st_dout, exp_st);
        wait_event(3, 4096, "vint", gap);
        bus_read(REG_STATUS);
        check_byte("frame count after vint", st_dout, exp_st + 8'd1);

        // Random register traffic including upper lane writes
        repeat (200) begin
            sel = reg_sel_e'($urandom_range(2));
            bus_write(sel, 2'($urandom), 16'($urandom));
            bus_read(sel);
        end

        // Latch interrupt set and cleared, then a write racing an ack
        send_ack();
        bus_write(REG_LATCH, 2'b10, 16'($urandom));
        send_ack();
        snd_ack = 1'b1;
        bus_write(REG_LATCH, 2'b00, 16'($urandom));
        snd_ack = 1'b0;

        // Back-to-back mapper requests under a new configuration every 50
        repeat (10) begin
            bus_write(REG_CTRL, 2'b00, 16'($urandom));
            bus_write(REG_BANK, 2'b00, 16'($urandom));
            repeat (50) begin
                obj_cs   = 1'($urandom);
                pre_addr = {$urandom, $urandom};
                exp_adj  = map_request(m_cfg, obj_cs, pre_addr);
                exp_cs   = m_cfg.video_en | obj_cs;
                @(negedge clk);
                check_adj("mapped address", adj_addr, exp_adj);
                check_byte("gfx_cs", {7'd0, gfx_cs}, {7'd0, exp_cs});
            end
        end

        // Status mux with hold on unmapped addresses
        exp_st = 8'd0;
        for (int i = 0; i < 300; i++) begin
            if (i == 0)
                st_addr = 8'd0;
            else if ($urandom_range(1))
                st_addr = 8'($urandom);
            else
                st_addr = {4'($urandom_range(4)), 4'($urandom_range(3))};
            exp_st = status_value(st_addr, exp_st);
            @(negedge clk);
            check_byte("status port", st_dout, exp_st);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+dv
hdl/arc_game_pkg.sv
hdl/arc_cen.sv
hdl/arc_vtimer.sv
hdl/arc_mem_map.sv
hdl/arc_sys_regs.sv
hdl/arc_game.sv
dv/arc_game_tb.sv

// File: Bender.yml
package:
  name: arc_game

sources:
  - files:
      - hdl/arc_game_pkg.sv
      - hdl/arc_cen.sv
      - hdl/arc_vtimer.sv
      - hdl/arc_mem_map.sv
      - hdl/arc_sys_regs.sv
      - hdl/arc_game.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/arc_game_tb.sv
